// File: build.f
source/rvPkg.sv
source/instrDecode.sv
source/regFile.sv
source/aluUnit.sv
source/coreControl.sv
source/rvCore.sv
bench/coreTb.sv

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log
set -u

LOG=sim.log

verilator --binary --timing -f build.f --top-module coreTb --Mdir obj_dir -o coreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/coreSim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi
exit 1

// File: bench/coreTb.sv
// Testbench for rvCore, acts as the memory and runs directed RV32I programs on the core
module coreTb
    import rvPkg::*;
();

    localparam logic [11:0] DATA_BASE = 12'h600;
    localparam logic [31:0] ECALL     = 32'h0000_0073;

    bit          clock;
    logic        rstN;
    logic        memReqValid;
    memReqT      memReq;
    logic        memReqReady;
    logic        memRspValid;
    logic [31:0] memRspData;
    logic        halted;

    // Word memory, indexed by address bits 11:2
    logic [31:0] mem [0:1023];
    logic [31:0] progPtr;
    int          errors;
    int          checks;
    int          stallCount;
    bit          stallOn;
    // Operands kept so the back-pressure run repeats the same program
    logic [31:0] arithA;
    logic [31:0] arithB;
    logic [11:0] arithImmI;
    logic [19:0] arithImmU;

    rvCore u_rvCore (
        .clock       (clock),
        .rstN        (rstN),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memReqReady (memReqReady),
        .memRspValid (memRspValid),
        .memRspData  (memRspData),
        .halted      (halted)
    );

    initial
    begin
        forever #2 clock = ~clock;
    end

    // Instruction formats
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return iType(imm, rs1, 3'b000, rd, 7'b0010011);
    endfunction

    // SW and LW always use x0 as the base
    function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [11:0] off);
        return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] loadWord(input logic [4:0] rd, input logic [11:0] off);
        return iType(off, 5'd0, 3'b010, rd, 7'b0000011);
    endfunction

    // Background word, never a legal opcode since bits 1:0 are zero
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return addr ^ 32'hA5C3_0F00;
    endfunction

    // Reference results of the RV32I register operations
    function automatic logic [31:0] expectAlu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        logic       lts;
        sh  = b[4:0];
        // Signed less-than from the sign bits
        lts = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'd0, lts};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? ((a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0)) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branchRule(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        logic lts;
        lts = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return lts;
            3'd5: return !lts;
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[progPtr[11:2]] = word;
        progPtr += 4;
    endtask

    // LUI plus ADDI, upper part rounded for the signed low part
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(uType(upper[31:12], rd, 7'b0110111));
        emit(addi(rd, rd, value[11:0]));
    endtask

    task automatic clearMemory();
        for (int i = 0; i < 1024; i++)
        begin
            mem[i] = fillWord(32'(i) << 2);
        end
        progPtr = '0;
    endtask

    task automatic checkSlot(input logic [11:0] off, input logic [31:0] expected);
        checks++;
        if (mem[off[11:2]] !== expected)
        begin
            errors++;
            $display("Fail mem[%08h] expected %08h actual %08h", {20'h0, off}, expected,
                     mem[off[11:2]]);
        end
    endtask

    // Memory model, ready withheld 0 to 3 cycles, read data 1 to 3 cycles after acceptance
    task automatic serveMemory();
        int          holdLeft;
        int          rspLeft;
        bit          holding;
        memReqT      heldReq;
        logic [31:0] rspWord;
        holdLeft = 0;
        rspLeft  = 0;
        holding  = 1'b0;
        heldReq  = '0;
        rspWord  = '0;
        forever
        begin
            @(negedge clock);
            if (!rstN)
            begin
                memReqReady = 1'b0;
                memRspValid = 1'b0;
                holding     = 1'b0;
                rspLeft     = 0;
            end
            else
            begin
                memRspValid = 1'b0;
                if (rspLeft > 0)
                begin
                    rspLeft--;
                    if (rspLeft == 0)
                    begin
                        memRspValid = 1'b1;
                        memRspData  = rspWord;
                    end
                end
                memReqReady = 1'b0;
                if (memReqValid)
                begin
                    if (!holding)
                    begin
                        holding  = 1'b1;
                        heldReq  = memReq;
                        holdLeft = stallOn ? $urandom_range(3, 0) : 0;
                        // Fetch and data addresses of these programs are word aligned
                        if (memReq.addr[1:0] !== 2'b00)
                        begin
                            errors++;
                            $display("Fail memReq.addr expected %08h actual %08h",
                                     {memReq.addr[31:2], 2'b00}, memReq.addr);
                        end
                    end
                    else if (memReq !== heldReq)
                    begin
                        errors++;
                        $display("Fail memReq expected %h actual %h", heldReq, memReq);
                    end
                    if (holdLeft == 0)
                    begin
                        // Ready now, so the next rising edge takes the request
                        memReqReady = 1'b1;
                        holding     = 1'b0;
                        if (memReq.write)
                            mem[memReq.addr[11:2]] = memReq.wdata;
                        else
                        begin
                            rspWord = mem[memReq.addr[11:2]];
                            rspLeft = $urandom_range(3, 1);
                        end
                    end
                    else
                    begin
                        holdLeft--;
                        stallCount++;
                    end
                end
            end
        end
    endtask

    task automatic runProgram(input string what);
        int cycles;
        @(negedge clock);
        rstN = 1'b0;
        repeat (3) @(negedge clock);
        rstN   = 1'b1;
        cycles = 0;
        while (halted !== 1'b1 && cycles < 5000)
        begin
            @(negedge clock);
            cycles++;
        end
        if (halted !== 1'b1)
        begin
            errors++;
            $display("The %s program did not halt within %0d cycles", what, cycles);
        end
    endtask

    // ADDI, LUI, AUIPC and the ten register operations
    task automatic arithTest(input bit stall, input bit fresh);
        logic [2:0]  f3s [0:9];
        logic [9:0]  altMask;
        logic [31:0] expected [0:12];
        logic [31:0] auipcAddr;
        int          k;
        f3s     = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        // SUB and SRA
        altMask = 10'b0010000010;
        if (fresh)
        begin
            arithA    = $urandom();
            arithB    = $urandom();
            arithImmI = 12'($urandom());
            arithImmU = 20'($urandom());
        end
        stallOn    = stall;
        stallCount = 0;
        clearMemory();
        loadConst(5'd1, arithA);
        loadConst(5'd2, arithB);
        emit(addi(5'd3, 5'd1, arithImmI));
        emit(storeWord(5'd3, DATA_BASE));
        expected[0] = arithA + {{20{arithImmI[11]}}, arithImmI};
        emit(uType(arithImmU, 5'd4, 7'b0110111));
        emit(storeWord(5'd4, DATA_BASE + 12'd4));
        expected[1] = {arithImmU, 12'h000};
        auipcAddr = progPtr;
        emit(uType(arithImmU, 5'd5, 7'b0010111));
        emit(storeWord(5'd5, DATA_BASE + 12'd8));
        expected[2] = auipcAddr + {arithImmU, 12'h000};
        for (k = 0; k < 10; k++)
        begin
            emit(rType(altMask[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[k], 5'd6, 7'b0110011));
            emit(storeWord(5'd6, DATA_BASE + 12'(12 + 4 * k)));
            expected[3 + k] = expectAlu(f3s[k], altMask[k], arithA, arithB);
        end
        emit(ECALL);
        runProgram(stall ? "back-pressure arithmetic" : "arithmetic");
        for (k = 0; k < 13; k++)
        begin
            checkSlot(DATA_BASE + 12'(4 * k), expected[k]);
        end
        if (stall && stallCount == 0)
        begin
            errors++;
            $display("The memory never withheld its ready during the back-pressure run");
        end
    endtask

    // Writes to x0 are lost, and a load then store copies a word
    task automatic zeroRegTest();
        logic [31:0] word;
        word    = $urandom();
        stallOn = 1'b1;
        clearMemory();
        mem[12'h700 >> 2] = word;
        emit(addi(5'd0, 5'd0, 12'h055));
        emit(storeWord(5'd0, DATA_BASE));
        loadConst(5'd1, 32'h1234_5678);
        emit(rType(7'h00, 5'd1, 5'd1, 3'b000, 5'd0, 7'b0110011));
        emit(storeWord(5'd0, DATA_BASE + 12'd4));
        emit(loadWord(5'd7, 12'h700));
        emit(storeWord(5'd7, 12'h704));
        emit(ECALL);
        runProgram("x0 and load");
        checkSlot(DATA_BASE, 32'h0);
        checkSlot(DATA_BASE + 12'd4, 32'h0);
        checkSlot(12'h704, word);
    endtask

    // Marker 2 on the taken path, marker 1 on the fall-through path
    task automatic branchTest();
        logic [31:0] pa [0:4];
        logic [31:0] pb [0:4];
        logic [2:0]  f3;
        logic [11:0] off;
        int          p;
        int          j;
        pa      = '{32'd5, 32'hFFFF_FFFF, 32'd1, 32'd3, $urandom()};
        pb      = '{32'd5, 32'd1, 32'hFFFF_FFFF, 32'd7, $urandom()};
        stallOn = 1'b1;
        clearMemory();
        for (p = 0; p < 5; p++)
        begin
            for (j = 0; j < 6; j++)
            begin
                f3  = 3'(j < 2 ? j : j + 2);
                off = DATA_BASE + 12'(4 * (p * 6 + j));
                loadConst(5'd1, pa[p]);
                loadConst(5'd2, pb[p]);
                emit(bType(13'd16, 5'd2, 5'd1, f3));
                emit(addi(5'd9, 5'd0, 12'd1));
                emit(storeWord(5'd9, off));
                emit(jType(21'd12, 5'd0));
                emit(addi(5'd9, 5'd0, 12'd2));
                emit(storeWord(5'd9, off));
            end
        end
        emit(ECALL);
        runProgram("branch");
        for (p = 0; p < 5; p++)
        begin
            for (j = 0; j < 6; j++)
            begin
                f3 = 3'(j < 2 ? j : j + 2);
                checkSlot(DATA_BASE + 12'(4 * (p * 6 + j)),
                          branchRule(f3, pa[p], pb[p]) ? 32'd2 : 32'd1);
            end
        end
    endtask

    // JAL over two words, then JALR to an odd address
    task automatic jumpTest();
        logic [31:0] jalAddr;
        logic [31:0] jalrAddr;
        logic [31:0] target;
        stallOn = 1'b1;
        clearMemory();
        jalAddr = progPtr;
        emit(jType(21'd12, 5'd10));
        emit(addi(5'd11, 5'd0, 12'h111));
        emit(storeWord(5'd11, DATA_BASE + 12'd8));
        emit(storeWord(5'd10, DATA_BASE));
        // Link register load takes two words, then JALR and two skipped words
        jalrAddr = progPtr + 32'd8;
        target   = jalrAddr + 32'd12;
        loadConst(5'd12, target + 32'd1);
        emit(iType(12'd0, 5'd12, 3'b000, 5'd13, 7'b1100111));
        emit(addi(5'd11, 5'd0, 12'h222));
        emit(storeWord(5'd11, DATA_BASE + 12'd12));
        emit(storeWord(5'd13, DATA_BASE + 12'd4));
        emit(ECALL);
        runProgram("jump");
        checkSlot(DATA_BASE, jalAddr + 32'd4);
        checkSlot(DATA_BASE + 12'd4, jalrAddr + 32'd4);
        checkSlot(DATA_BASE + 12'd8, fillWord({20'h0, DATA_BASE + 12'd8}));
        checkSlot(DATA_BASE + 12'd12, fillWord({20'h0, DATA_BASE + 12'd12}));
    endtask

    task automatic checkQuiet();
        int n;
        for (n = 0; n < 20; n++)
        begin
            @(negedge clock);
            if (memReqValid !== 1'b0)
            begin
                errors++;
                $display("Fail memReqValid expected 0 actual %h", memReqValid);
            end
            if (halted !== 1'b1)
            begin
                errors++;
                $display("Fail halted expected 1 actual %h", halted);
            end
        end
    endtask

    // ECALL, then an undefined opcode, each followed by a store that must not run
    task automatic haltTest();
        logic [31:0] stopWord [0:1];
        int          t;
        stopWord = '{ECALL, 32'h0000_000B};
        stallOn  = 1'b1;
        for (t = 0; t < 2; t++)
        begin
            clearMemory();
            emit(addi(5'd1, 5'd0, 12'(12'h05A + t)));
            emit(storeWord(5'd1, DATA_BASE));
            emit(stopWord[t]);
            emit(storeWord(5'd1, DATA_BASE + 12'd4));
            runProgram(t == 0 ? "ECALL" : "undefined opcode");
            checkQuiet();
            checkSlot(DATA_BASE, 32'(12'h05A + t));
            checkSlot(DATA_BASE + 12'd4, fillWord({20'h0, DATA_BASE + 12'd4}));
        end
    endtask

    initial
    begin
        void'($urandom(32'h78a5));
        rstN        = 1'b0;
        memReqReady = 1'b0;
        memRspValid = 1'b0;
        memRspData  = '0;
        errors      = 0;
        checks      = 0;
        stallCount  = 0;
        stallOn     = 1'b0;
        progPtr     = '0;
        fork
            serveMemory();
        join_none
        arithTest(1'b0, 1'b1);
        zeroRegTest();
        branchTest();
        jumpTest();
        haltTest();
        // Same arithmetic program, now with a stalling memory
        arithTest(1'b1, 1'b0);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: source/rvCore.sv
// Top of the RV32I multicycle core, joins decoder, registers, ALU and controller to memory
module rvCore
    import rvPkg::*;
(
    input  logic            clock,
    input  logic            rstN,
    output logic            memReqValid,
    output memReqT          memReq,
    input  logic            memReqReady,
    input  logic            memRspValid,
    input  logic [XLEN-1:0] memRspData,
    output logic            halted
);

    // Decoder side
    logic [31:0]     instr;
    decodeCtrlT      ctrl;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    // Register file side
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic            wrEn;
    logic [XLEN-1:0] wrData;
    // ALU side
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluResult;
    logic            branchTaken;

    instrDecode u_instrDecode (
        .instr (instr),
        .ctrl  (ctrl),
        .rd    (rd),
        .rs1   (rs1),
        .rs2   (rs2)
    );

    regFile u_regFile (
        .clock   (clock),
        .rstN    (rstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // Comparator always sees the raw register values
    aluUnit u_aluUnit (
        .aluOp       (ctrl.aluOp),
        .branchOp    (ctrl.branchOp),
        .opA         (opA),
        .opB         (opB),
        .cmpA        (rs1Data),
        .cmpB        (rs2Data),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    coreControl u_coreControl (
        .clock       (clock),
        .rstN        (rstN),
        .ctrl        (ctrl),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .memReqReady (memReqReady),
        .memRspValid (memRspValid),
        .memRspData  (memRspData),
        .instr       (instr),
        .opA         (opA),
        .opB         (opB),
        .wrEn        (wrEn),
        .wrData      (wrData),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .halted      (halted)
    );

endmodule

// File: source/coreControl.sv
// Multicycle controller, owns PC, instruction register and the memory port handshake
module coreControl
    import rvPkg::*;
(
    input  logic            clock,
    input  logic            rstN,
    input  decodeCtrlT      ctrl,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    input  logic [XLEN-1:0] aluResult,
    input  logic            branchTaken,
    input  logic            memReqReady,
    input  logic            memRspValid,
    input  logic [XLEN-1:0] memRspData,
    output logic [31:0]     instr,
    output logic [XLEN-1:0] opA,
    output logic [XLEN-1:0] opB,
    output logic            wrEn,
    output logic [XLEN-1:0] wrData,
    output logic            memReqValid,
    output memReqT          memReq,
    output logic            halted
);

    coreStateE       state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcPlusImm;
    logic [XLEN-1:0] nextPc;
    logic            reqAccept;

    assign pcPlus4   = pc + XLEN'(4);
    assign pcPlusImm = pc + ctrl.imm;
    assign reqAccept = memReqValid && memReqReady;

    // Operand selection
    always_comb
    begin
        case (ctrl.srcA)
            SRCA_PC:   opA = pc;
            SRCA_ZERO: opA = '0;
            default:   opA = rs1Data;
        endcase
    end
    assign opB = ctrl.immSrcB ? ctrl.imm : rs2Data;

    // JALR target has bit 0 cleared
    always_comb
    begin
        if (ctrl.isJal || (ctrl.isBranch && branchTaken))
            nextPc = pcPlusImm;
        else if (ctrl.isJalr)
            nextPc = {aluResult[XLEN-1:1], 1'b0};
        else
            nextPc = pcPlus4;
    end

    // Write-back in EXECUTE, or in WAIT_LOAD when the data arrives
    assign wrEn = (state == ST_EXECUTE && ctrl.regWrite && !ctrl.memRead && !ctrl.illegal) ||
                  (state == ST_WAIT_LOAD && memRspValid);

    always_comb
    begin
        case (ctrl.wbSel)
            WB_PC4:  wrData = pcPlus4;
            WB_MEM:  wrData = memRspData;
            default: wrData = aluResult;
        endcase
    end

    assign halted = state == ST_HALT;

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            state       <= ST_FETCH;
            pc          <= RESET_PC;
            memReqValid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_FETCH, ST_MEM:
                begin
                    // Raise the request, then drop it once accepted
                    if (!memReqValid)
                        memReqValid <= 1'b1;
                    else if (reqAccept)
                    begin
                        memReqValid <= 1'b0;
                        if (state == ST_FETCH)
                            state <= ST_WAIT_INSTR;
                        else if (memReq.write)
                        begin
                            // Store done on acceptance
                            pc    <= pcPlus4;
                            state <= ST_FETCH;
                        end
                        else
                            state <= ST_WAIT_LOAD;
                    end
                end
                ST_WAIT_INSTR:
                begin
                    if (memRspValid)
                        state <= ST_EXECUTE;
                end
                ST_EXECUTE:
                begin
                    if (ctrl.illegal || ctrl.isSystem)
                        state <= ST_HALT;
                    else if (ctrl.memRead || ctrl.memWrite)
                        state <= ST_MEM;
                    else
                    begin
                        pc    <= nextPc;
                        state <= ST_FETCH;
                    end
                end
                ST_WAIT_LOAD:
                begin
                    if (memRspValid)
                    begin
                        pc    <= pcPlus4;
                        state <= ST_FETCH;
                    end
                end
                default:
                begin
                    // HALT holds until reset
                    state <= ST_HALT;
                end
            endcase
        end
    end

    // Request payload and instruction register
    always_ff @(posedge clock)
    begin
        // Loaded only while no request is pending, so it holds under back-pressure
        if (state == ST_FETCH && !memReqValid)
            memReq <= '{addr: pc, wdata: '0, write: 1'b0};
        else if (state == ST_MEM && !memReqValid)
            memReq <= '{addr: aluResult, wdata: rs2Data, write: ctrl.memWrite};
        if (state == ST_WAIT_INSTR && memRspValid)
            instr <= memRspData;
    end

endmodule

// File: source/aluUnit.sv
// Integer ALU with the branch comparator alongside
module aluUnit
    import rvPkg::*;
(
    input  aluOpE           aluOp,
    input  branchOpE        branchOp,
    input  logic [XLEN-1:0] opA,
    input  logic [XLEN-1:0] opB,
    input  logic [XLEN-1:0] cmpA,
    input  logic [XLEN-1:0] cmpB,
    output logic [XLEN-1:0] aluResult,
    output logic            branchTaken
);

    logic [4:0] shamt;
    logic       opLtS;
    logic       opLtU;
    logic       cmpEq;
    logic       cmpLtS;
    logic       cmpLtU;

    // Shift amount is the low five bits only
    assign shamt  = opB[4:0];
    assign opLtS  = $signed(opA) < $signed(opB);
    assign opLtU  = opA < opB;

    // Branch compares the two register values
    assign cmpEq  = cmpA == cmpB;
    assign cmpLtS = $signed(cmpA) < $signed(cmpB);
    assign cmpLtU = cmpA < cmpB;

    always_comb
    begin
        case (aluOp)
            ALU_SUB:  aluResult = opA - opB;
            ALU_SLL:  aluResult = opA << shamt;
            ALU_SLT:  aluResult = {{(XLEN-1){1'b0}}, opLtS};
            ALU_SLTU: aluResult = {{(XLEN-1){1'b0}}, opLtU};
            ALU_XOR:  aluResult = opA ^ opB;
            ALU_SRL:  aluResult = opA >> shamt;
            ALU_SRA:  aluResult = $unsigned($signed(opA) >>> shamt);
            ALU_OR:   aluResult = opA | opB;
            ALU_AND:  aluResult = opA & opB;
            default:  aluResult = opA + opB;
        endcase
    end

    always_comb
    begin
        case (branchOp)
            BR_BNE:  branchTaken = !cmpEq;
            BR_BLT:  branchTaken = cmpLtS;
            BR_BGE:  branchTaken = !cmpLtS;
            BR_BLTU: branchTaken = cmpLtU;
            BR_BGEU: branchTaken = !cmpLtU;
            default: branchTaken = cmpEq;
        endcase
    end

endmodule

// File: source/regFile.sv
// Integer register file, two asynchronous reads and one clocked write, x0 tied to zero
module regFile
    import rvPkg::*;
(
    input  logic            clock,
    input  logic            rstN,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            wrEn,
    input  logic [XLEN-1:0] wrData,
    output logic [XLEN-1:0] rs1Data,
    output logic [XLEN-1:0] rs2Data
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && rd != 5'd0)
        begin
            regs[rd] <= wrData;
        end
    end

    // Reads of x0 return zero
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: source/instrDecode.sv
// Combinational RV32I decoder, turns the held instruction into fields, immediate and controls
module instrDecode
    import rvPkg::*;
(
    input  logic [31:0] instr,
    output decodeCtrlT  ctrl,
    output logic [4:0]  rd,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2
);

    opcodeE          opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;
    // ALU op picked from funct3 and the alternate bit
    aluOpE           f3AluOp;
    logic            altBit;
    logic            funct7Ok;

    // Fixed field positions
    assign opcode = opcodeE'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // Immediates, all sign extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // OP uses bit 30 for SUB and SRA, OP-IMM only for SRAI
    assign altBit = funct7[5] && (opcode == OPC_OP || funct3 == 3'b101);

    always_comb
    begin
        case (funct3)
            3'b000: f3AluOp = altBit ? ALU_SUB : ALU_ADD;
            3'b001: f3AluOp = ALU_SLL;
            3'b010: f3AluOp = ALU_SLT;
            3'b011: f3AluOp = ALU_SLTU;
            3'b100: f3AluOp = ALU_XOR;
            3'b101: f3AluOp = altBit ? ALU_SRA : ALU_SRL;
            3'b110: f3AluOp = ALU_OR;
            default: f3AluOp = ALU_AND;
        endcase
    end

    // Legal funct3/funct7 pairs
    always_comb
    begin
        if (opcode == OPC_OP)
            funct7Ok = funct7 == 7'b0 ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        else if (funct3 == 3'b001)
            funct7Ok = funct7 == 7'b0;
        else if (funct3 == 3'b101)
            funct7Ok = funct7 == 7'b0 || funct7 == 7'b0100000;
        else
            funct7Ok = 1'b1;
    end

    always_comb
    begin
        // Defaults describe a no-op that writes nothing
        ctrl          = '0;
        ctrl.aluOp    = ALU_ADD;
        ctrl.branchOp = branchOpE'(funct3);
        ctrl.srcA     = SRCA_RS1;
        ctrl.wbSel    = WB_ALU;
        ctrl.imm      = immI;

        case (opcode)
            OPC_LUI:
            begin
                // 0 + U immediate
                ctrl.srcA     = SRCA_ZERO;
                ctrl.immSrcB  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.imm      = immU;
            end
            OPC_AUIPC:
            begin
                ctrl.srcA     = SRCA_PC;
                ctrl.immSrcB  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.imm      = immU;
            end
            OPC_JAL:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = WB_PC4;
                ctrl.isJal    = 1'b1;
                ctrl.imm      = immJ;
            end
            OPC_JALR:
            begin
                // Target rs1 + imm comes out of the ALU
                ctrl.immSrcB  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = WB_PC4;
                ctrl.isJalr   = 1'b1;
                ctrl.illegal  = funct3 != 3'b000;
            end
            OPC_BRANCH:
            begin
                ctrl.isBranch = 1'b1;
                ctrl.imm      = immB;
                // funct3 010 and 011 are not branches
                ctrl.illegal  = funct3[2:1] == 2'b01;
            end
            OPC_LOAD:
            begin
                ctrl.immSrcB  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.wbSel    = WB_MEM;
                ctrl.illegal  = funct3 != 3'b010;
            end
            OPC_STORE:
            begin
                ctrl.immSrcB  = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.imm      = immS;
                ctrl.illegal  = funct3 != 3'b010;
            end
            OPC_OPIMM:
            begin
                ctrl.aluOp    = f3AluOp;
                ctrl.immSrcB  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.illegal  = !funct7Ok;
            end
            OPC_OP:
            begin
                ctrl.aluOp    = f3AluOp;
                ctrl.regWrite = 1'b1;
                ctrl.illegal  = !funct7Ok;
            end
            OPC_SYSTEM:
            begin
                // ECALL or EBREAK, CSR forms are not supported
                ctrl.isSystem = 1'b1;
                ctrl.illegal  = funct3 != 3'b000;
            end
            default:
            begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: source/rvPkg.sv
// Shared types and constants of the RV32I core, imported by every RTL block
package rvPkg;

    // Data and address width
    localparam int XLEN = 32;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes, encoded as in instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcodeE;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluOpE;

    // Branch conditions, values equal to funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchOpE;

    // First ALU operand, zero is for LUI
    typedef enum logic [1:0] {
        SRCA_RS1,
        SRCA_PC,
        SRCA_ZERO
    } srcAE;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_MEM
    } wbSelE;

    // Controller states
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_WAIT_INSTR,
        ST_EXECUTE,
        ST_MEM,
        ST_WAIT_LOAD,
        ST_HALT
    } coreStateE;

    // Decoder output, 52 bits
    typedef struct packed {
        aluOpE           aluOp;
        branchOpE        branchOp;
        srcAE            srcA;
        wbSelE           wbSel;
        logic            immSrcB;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic            isBranch;
        logic            isJal;
        logic            isJalr;
        logic            isSystem;
        logic            illegal;
        logic [XLEN-1:0] imm;
    } decodeCtrlT;

    // One request on the shared memory port
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            write;
    } memReqT;

endpackage
